/* dv/executeStageTb.sv */
module executeStageTb;

    timeunit 1ns;
    timeprecision 1ps;

    typedef struct packed {
        logic regWrite, memWrite, byteAddr, aluSrc;
        rvPkg::resultKind resultSrc;
        rvPkg::jumpKind jumpType;
        rvPkg::branchKind branchType;
        rvPkg::aluOp aluControl;
        rvPkg::dataWord rd1, rd2, pc, immExt, pcPlus4;
        rvPkg::regAddr rs1, rs2, rd;
    } decodeFields;

    typedef struct packed {
        logic regWrite, memWrite, byteAddr;
        rvPkg::resultKind resultSrc;
        rvPkg::dataWord aluResult, writeData, pcPlus4;
        rvPkg::regAddr rd;
    } memFields;

    localparam int modeAlu = 0, modeBranch = 1, modeFwd = 2, modeFlush = 3, modePass = 4;
    // each test also runs two trailing bubbles
    localparam int totalCycles = 4 + 202 + 102 + 202 + 102 + 202;
    localparam int cycleLimit = 2 * totalCycles + 20;

    logic clk, rstN, clr, regWriteW;
    rvPkg::regAddr rdW, rdM;
    rvPkg::dataWord resultW;
    logic pcSrcE, regWriteM, memWriteM, byteAddrM;
    rvPkg::resultKind resultSrcM;
    rvPkg::dataWord pcTargetE, aluResultM, writeDataM, pcPlus4M;
    // d holds the driven inputs while e and m shadow the two pipeline registers
    decodeFields d, e;
    memFields m;
    int seed = 32'h5ba9598b;
    int cycleCount = 0;
    int errors = 0;
    int passCount = 0;
    int failCount = 0;
    string testName;

    executeStage #(
        .dataWidth    (32),
        .regAddrWidth (5)
    ) u_dut (
        .clk, .rstN, .clr,
        .regWriteD(d.regWrite), .resultSrcD(d.resultSrc), .memWriteD(d.memWrite),
        .byteAddrD(d.byteAddr), .jumpTypeD(d.jumpType), .branchTypeD(d.branchType),
        .aluControlD(d.aluControl), .aluSrcD(d.aluSrc), .rd1D(d.rd1), .rd2D(d.rd2),
        .pcD(d.pc), .rs1D(d.rs1), .rs2D(d.rs2), .rdD(d.rd), .immExtD(d.immExt),
        .pcPlus4D(d.pcPlus4), .rdW, .regWriteW, .resultW, .pcSrcE, .pcTargetE,
        .regWriteM, .resultSrcM, .memWriteM, .byteAddrM, .aluResultM, .writeDataM,
        .rdM, .pcPlus4M
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount > cycleLimit) begin
            $display("timeout: the run did not finish within %0d cycles", cycleLimit);
            $display(">>> FAIL");
            $finish;
        end
    end

    task automatic reportMismatch(input string what, input logic [31:0] expected,
                                  input logic [31:0] actual);
        $display("FAIL %s %s: expected %0h actual %0h", testName, what, expected, actual);
        errors++;
    endtask

    task automatic checkWord(input string what, input rvPkg::dataWord expected,
                             input rvPkg::dataWord actual);
        if (actual !== expected) reportMismatch(what, expected, actual);
    endtask

    task automatic checkReg(input string what, input rvPkg::regAddr expected,
                            input rvPkg::regAddr actual);
        if (actual !== expected) reportMismatch(what, 32'(expected), 32'(actual));
    endtask

    task automatic checkBit(input string what, input logic expected, input logic actual);
        if (actual !== expected) reportMismatch(what, 32'(expected), 32'(actual));
    endtask

    task automatic checkKind(input string what, input rvPkg::resultKind expected,
                             input rvPkg::resultKind actual);
        if (actual !== expected) reportMismatch(what, 32'(expected), 32'(actual));
    endtask

    // memory stage before writeback and never for x0 or a load
    function automatic rvPkg::dataWord pickOperand(input rvPkg::regAddr rs,
                                                   input rvPkg::dataWord regVal);
        if (rs == 5'd0) return regVal;
        if (m.regWrite && m.resultSrc == rvPkg::resAlu && m.rd == rs) return m.aluResult;
        if (regWriteW && rdW == rs) return resultW;
        return regVal;
    endfunction

    function automatic rvPkg::dataWord aluModel(input rvPkg::aluOp op, input rvPkg::dataWord a,
                                                input rvPkg::dataWord b);
        case (op)
            rvPkg::aluAdd: return a + b;
            rvPkg::aluSub: return a - b;
            rvPkg::aluAnd: return a & b;
            rvPkg::aluOr:  return a | b;
            rvPkg::aluXor: return a ^ b;
            rvPkg::aluSlt: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            rvPkg::aluSll: return a << b[4:0];
            default:       return a >> b[4:0];
        endcase
    endfunction

    task automatic checkOutputs();
        rvPkg::dataWord a;
        rvPkg::dataWord b;
        logic taken;
        a = pickOperand(e.rs1, e.rd1);
        b = pickOperand(e.rs2, e.rd2);
        case (e.branchType)
            rvPkg::brBeq: taken = a == b;
            rvPkg::brBne: taken = a != b;
            rvPkg::brBlt: taken = $signed(a) < $signed(b);
            default:      taken = 1'b0;
        endcase
        checkBit("pcSrcE", taken || e.jumpType != rvPkg::jmpNone, pcSrcE);
        // jalr is register relative with an even target
        if (e.jumpType == rvPkg::jmpJalr) begin
            checkWord("pcTargetE", (a + e.immExt) & ~32'd1, pcTargetE);
        end else begin
            checkWord("pcTargetE", e.pc + e.immExt, pcTargetE);
        end
        checkBit("regWriteM", m.regWrite, regWriteM);
        checkKind("resultSrcM", m.resultSrc, resultSrcM);
        checkBit("memWriteM", m.memWrite, memWriteM);
        checkBit("byteAddrM", m.byteAddr, byteAddrM);
        checkWord("aluResultM", m.aluResult, aluResultM);
        checkWord("writeDataM", m.writeData, writeDataM);
        checkReg("rdM", m.rd, rdM);
        checkWord("pcPlus4M", m.pcPlus4, pcPlus4M);
    endtask

    // model of one rising edge, forwarding from the old m
    task automatic advanceModel();
        rvPkg::dataWord a;
        rvPkg::dataWord b;
        a = pickOperand(e.rs1, e.rd1);
        b = pickOperand(e.rs2, e.rd2);
        m = {e.regWrite, e.memWrite, e.byteAddr, e.resultSrc,
             aluModel(e.aluControl, a, e.aluSrc ? e.immExt : b), b, e.pcPlus4, e.rd};
        e = clr ? '0 : d;
    endtask

    task automatic driveRandom(input int mode, input int idx);
        logic [31:0] r;
        logic [31:0] k;
        logic noWrites;
        r = $random(seed);
        noWrites = mode == modeAlu || mode == modeBranch;
        d.regWrite = noWrites ? 1'b0 : r[0];
        d.memWrite = r[1];
        d.byteAddr = r[2];
        d.aluSrc = r[3];
        d.resultSrc = rvPkg::resultKind'(r[5:4] % 2'd3);
        d.aluControl = rvPkg::aluOp'(r[8:6]);
        if (mode == modeBranch) begin
            d.branchType = rvPkg::branchKind'(2'(idx % 4));
            d.jumpType = rvPkg::jumpKind'(2'((idx / 4) % 3));
        end else if (mode == modeFlush) begin
            // flushed branches and jumps must not redirect
            k = $random(seed);
            d.branchType = rvPkg::branchKind'(k[1:0]);
            d.jumpType = rvPkg::jumpKind'(k[3:2] % 2'd3);
        end else begin
            d.branchType = rvPkg::brNone;
            d.jumpType = rvPkg::jmpNone;
        end
        // only x0..x3 in the forwarding test so producers and consumers collide
        d.rs1 = (mode == modeFwd) ? {3'b000, r[10:9]} : r[13:9];
        d.rs2 = (mode == modeFwd) ? {3'b000, r[15:14]} : r[18:14];
        d.rd = (mode == modeFwd) ? {3'b000, r[20:19]} : r[23:19];
        d.rd1 = $random(seed);
        d.rd2 = (mode == modeBranch && r[24]) ? d.rd1 : $random(seed);
        d.pc = $random(seed);
        d.immExt = $random(seed);
        d.pcPlus4 = d.pc + 32'd4;
        regWriteW = noWrites ? 1'b0 : r[25];
        rdW = (mode == modeFwd) ? {3'b000, r[27:26]} : r[29:25];
        resultW = $random(seed);
        clr = mode == modeFlush && r[31:30] == 2'b00;
    endtask

    task automatic reportTest(input int cycles);
        if (errors == 0) passCount++;
        else failCount++;
        $display("test %s: %0d cycles, %0d mismatches", testName, cycles, errors);
        errors = 0;
    endtask

    task automatic runTest(input string name, input int mode, input int count);
        testName = name;
        for (int i = 0; i < count + 2; i++) begin
            driveRandom(mode, i);
            if (i >= count) clr = 1'b1;
            @(negedge clk);
            checkOutputs();
            @(posedge clk);
            advanceModel();
            #5;
        end
        reportTest(count + 2);
    endtask

    initial begin
        rstN = 1'b0;
        clr = 1'b0;
        regWriteW = 1'b0;
        rdW = '0;
        resultW = '0;
        d = '0;
        e = '0;
        m = '0;
        testName = "reset";
        repeat (3) @(posedge clk);
        @(negedge clk);
        checkOutputs();
        @(posedge clk);
        #5;
        rstN = 1'b1;
        reportTest(4);
        runTest("alu", modeAlu, 200);
        runTest("branch", modeBranch, 100);
        runTest("forward", modeFwd, 200);
        runTest("flush", modeFlush, 100);
        runTest("passthrough", modePass, 200);
        $display("tests passed %0d, failed %0d", passCount, failCount);
        if (failCount == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

/* executeStage.f */
logic/rvPkg.sv
logic/idExReg.sv
logic/forwardUnit.sv
logic/aluUnit.sv
logic/branchResolve.sv
logic/exMemReg.sv
logic/executeStage.sv
dv/executeStageTb.sv

/* logic/aluUnit.sv */
module aluUnit #(
    parameter int dataWidth = 32
) (
    input  rvPkg::dataWord  srcAE,
    input  rvPkg::dataWord  writeDataE,
    input  rvPkg::dataWord  immExtE,
    input  logic            aluSrcE,
    input  rvPkg::aluOp     aluControlE,
    output rvPkg::dataWord  aluResultE
);

    localparam int shamtWidth = $clog2(dataWidth);

    rvPkg::dataWord          srcB;
    logic [shamtWidth-1:0]   shamt;
    logic                    lessThan;

    // immediate replaces the second register operand
    assign srcB = aluSrcE ? immExtE : writeDataE;

    assign shamt = srcB[shamtWidth-1:0];

    // signed compare for slt
    assign lessThan = $signed(srcAE) < $signed(srcB);

    always_comb begin
        case (aluControlE)
            rvPkg::aluAdd: begin
                aluResultE = srcAE + srcB;
            end
            rvPkg::aluSub: begin
                aluResultE = srcAE - srcB;
            end
            rvPkg::aluAnd: begin
                aluResultE = srcAE & srcB;
            end
            rvPkg::aluOr: begin
                aluResultE = srcAE | srcB;
            end
            rvPkg::aluXor: begin
                aluResultE = srcAE ^ srcB;
            end
            rvPkg::aluSlt: begin
                aluResultE = {{(dataWidth-1){1'b0}}, lessThan};
            end
            rvPkg::aluSll: begin
                aluResultE = srcAE << shamt;
            end
            rvPkg::aluSrl: begin
                // logical, zeros shift in from the top
                aluResultE = srcAE >> shamt;
            end
            default: begin
                aluResultE = {dataWidth{1'b0}};
            end
        endcase
    end

endmodule

/* logic/branchResolve.sv */
module branchResolve #(
    parameter int dataWidth = 32
) (
    input  rvPkg::dataWord    srcAE,
    input  rvPkg::dataWord    writeDataE,
    input  rvPkg::dataWord    pcE,
    input  rvPkg::dataWord    immExtE,
    input  rvPkg::branchKind  branchTypeE,
    input  rvPkg::jumpKind    jumpTypeE,
    output logic              pcSrcE,
    output rvPkg::dataWord    pcTargetE
);

    localparam logic [dataWidth-1:0] clearBit0 = {{(dataWidth-1){1'b1}}, 1'b0};

    logic            isEqual;
    logic            isLess;
    logic            takeBranch;
    logic            isJump;
    logic            isJalr;
    rvPkg::dataWord  targetBase;
    rvPkg::dataWord  targetSum;

    // compare the forwarded operands, not the raw register file reads
    assign isEqual = srcAE == writeDataE;
    assign isLess  = $signed(srcAE) < $signed(writeDataE);

    always_comb begin
        case (branchTypeE)
            rvPkg::brBeq: takeBranch = isEqual;
            rvPkg::brBne: takeBranch = !isEqual;
            rvPkg::brBlt: takeBranch = isLess;
            default:      takeBranch = 1'b0;
        endcase
    end

    assign isJalr = jumpTypeE == rvPkg::jmpJalr;
    assign isJump = (jumpTypeE == rvPkg::jmpJal) || isJalr;

    assign pcSrcE = isJump || takeBranch;

    // dedicated adder, jalr is register relative
    assign targetBase = isJalr ? srcAE : pcE;
    assign targetSum  = targetBase + immExtE;

    assign pcTargetE = isJalr ? (targetSum & clearBit0) : targetSum;

endmodule

/* logic/exMemReg.sv */
module exMemReg #(
    parameter int dataWidth    = 32,
    parameter int regAddrWidth = 5
) (
    input  logic              clk,
    input  logic              rstN,

    input  logic              regWriteE,
    input  rvPkg::resultKind  resultSrcE,
    input  logic              memWriteE,
    input  logic              byteAddrE,
    input  rvPkg::dataWord    aluResultE,
    input  rvPkg::dataWord    writeDataE,
    input  rvPkg::regAddr     rdE,
    input  rvPkg::dataWord    pcPlus4E,

    output logic              regWriteM,
    output rvPkg::resultKind  resultSrcM,
    output logic              memWriteM,
    output logic              byteAddrM,
    output rvPkg::dataWord    aluResultM,
    output rvPkg::dataWord    writeDataM,
    output rvPkg::regAddr     rdM,
    output rvPkg::dataWord    pcPlus4M
);

    // aluResultM and rdM double as the memory-stage forwarding source
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            regWriteM  <= 1'b0;
            resultSrcM <= rvPkg::resAlu;
            memWriteM  <= 1'b0;
            byteAddrM  <= 1'b0;
            aluResultM <= {dataWidth{1'b0}};
            writeDataM <= {dataWidth{1'b0}};
            rdM        <= {regAddrWidth{1'b0}};
            pcPlus4M   <= {dataWidth{1'b0}};
        end else begin
            regWriteM  <= regWriteE;
            resultSrcM <= resultSrcE;
            memWriteM  <= memWriteE;
            byteAddrM  <= byteAddrE;
            aluResultM <= aluResultE;
            // store data is the forwarded rs2 value
            writeDataM <= writeDataE;
            rdM        <= rdE;
            pcPlus4M   <= pcPlus4E;
        end
    end

endmodule

/* logic/executeStage.sv */
module executeStage #(
    parameter int dataWidth    = 32,
    parameter int regAddrWidth = 5
) (
    input  logic              clk,
    input  logic              rstN,
    input  logic              clr,

    input  logic              regWriteD,
    input  rvPkg::resultKind  resultSrcD,
    input  logic              memWriteD,
    input  logic              byteAddrD,
    input  rvPkg::jumpKind    jumpTypeD,
    input  rvPkg::branchKind  branchTypeD,
    input  rvPkg::aluOp       aluControlD,
    input  logic              aluSrcD,
    input  rvPkg::dataWord    rd1D,
    input  rvPkg::dataWord    rd2D,
    input  rvPkg::dataWord    pcD,
    input  rvPkg::regAddr     rs1D,
    input  rvPkg::regAddr     rs2D,
    input  rvPkg::regAddr     rdD,
    input  rvPkg::dataWord    immExtD,
    input  rvPkg::dataWord    pcPlus4D,

    // writeback forwarding source
    input  rvPkg::regAddr     rdW,
    input  logic              regWriteW,
    input  rvPkg::dataWord    resultW,

    output logic              pcSrcE,
    output rvPkg::dataWord    pcTargetE,

    output logic              regWriteM,
    output rvPkg::resultKind  resultSrcM,
    output logic              memWriteM,
    output logic              byteAddrM,
    output rvPkg::dataWord    aluResultM,
    output rvPkg::dataWord    writeDataM,
    output rvPkg::regAddr     rdM,
    output rvPkg::dataWord    pcPlus4M
);

    logic              regWriteE;
    rvPkg::resultKind  resultSrcE;
    logic              memWriteE;
    logic              byteAddrE;
    rvPkg::jumpKind    jumpTypeE;
    rvPkg::branchKind  branchTypeE;
    rvPkg::aluOp       aluControlE;
    logic              aluSrcE;
    rvPkg::dataWord    rd1E;
    rvPkg::dataWord    rd2E;
    rvPkg::dataWord    pcE;
    rvPkg::regAddr     rs1E;
    rvPkg::regAddr     rs2E;
    rvPkg::regAddr     rdE;
    rvPkg::dataWord    immExtE;
    rvPkg::dataWord    pcPlus4E;

    rvPkg::dataWord    srcAE;
    rvPkg::dataWord    writeDataE;
    rvPkg::dataWord    aluResultE;

    idExReg #(
        .dataWidth    (dataWidth),
        .regAddrWidth (regAddrWidth)
    ) uIdExReg (
        .clk, .rstN, .clr,
        .regWriteD, .resultSrcD, .memWriteD, .byteAddrD,
        .jumpTypeD, .branchTypeD, .aluControlD, .aluSrcD,
        .rd1D, .rd2D, .pcD, .rs1D, .rs2D, .rdD, .immExtD, .pcPlus4D,
        .regWriteE, .resultSrcE, .memWriteE, .byteAddrE,
        .jumpTypeE, .branchTypeE, .aluControlE, .aluSrcE,
        .rd1E, .rd2E, .pcE, .rs1E, .rs2E, .rdE, .immExtE, .pcPlus4E
    );

    // M-stage values feed back from the register below
    forwardUnit #(
        .dataWidth    (dataWidth),
        .regAddrWidth (regAddrWidth)
    ) uForwardUnit (
        .rs1E, .rs2E, .rdM, .rdW,
        .rd1E, .rd2E, .aluResultM, .resultW,
        .regWriteM, .regWriteW, .resultSrcM,
        .srcAE, .writeDataE
    );

    aluUnit #(
        .dataWidth (dataWidth)
    ) uAluUnit (
        .srcAE, .writeDataE, .immExtE, .aluSrcE, .aluControlE,
        .aluResultE
    );

    branchResolve #(
        .dataWidth (dataWidth)
    ) uBranchResolve (
        .srcAE, .writeDataE, .pcE, .immExtE, .branchTypeE, .jumpTypeE,
        .pcSrcE, .pcTargetE
    );

    exMemReg #(
        .dataWidth    (dataWidth),
        .regAddrWidth (regAddrWidth)
    ) uExMemReg (
        .clk, .rstN,
        .regWriteE, .resultSrcE, .memWriteE, .byteAddrE,
        .aluResultE, .writeDataE, .rdE, .pcPlus4E,
        .regWriteM, .resultSrcM, .memWriteM, .byteAddrM,
        .aluResultM, .writeDataM, .rdM, .pcPlus4M
    );

endmodule

/* logic/forwardUnit.sv */
module forwardUnit #(
    parameter int dataWidth    = 32,
    parameter int regAddrWidth = 5
) (
    input  rvPkg::regAddr     rs1E,
    input  rvPkg::regAddr     rs2E,
    input  rvPkg::regAddr     rdM,
    input  rvPkg::regAddr     rdW,
    input  rvPkg::dataWord    rd1E,
    input  rvPkg::dataWord    rd2E,
    input  rvPkg::dataWord    aluResultM,
    input  rvPkg::dataWord    resultW,
    input  logic              regWriteM,
    input  logic              regWriteW,
    input  rvPkg::resultKind  resultSrcM,
    output rvPkg::dataWord    srcAE,
    output rvPkg::dataWord    writeDataE
);

    rvPkg::fwdSel selA;
    rvPkg::fwdSel selB;

    // memory stage beats writeback; x0 is never forwarded
    // loads in the memory stage are left to the hazard unit's stall
    function automatic rvPkg::fwdSel pickSource(input rvPkg::regAddr src);
        if (src == {regAddrWidth{1'b0}}) begin
            return rvPkg::fwdRegFile;
        end else if (regWriteM && resultSrcM == rvPkg::resAlu && rdM == src) begin
            return rvPkg::fwdFromMem;
        end else if (regWriteW && rdW == src) begin
            return rvPkg::fwdFromWb;
        end
        return rvPkg::fwdRegFile;
    endfunction

    function automatic logic [dataWidth-1:0] muxOperand(input rvPkg::fwdSel sel,
                                                        input rvPkg::dataWord regVal);
        case (sel)
            rvPkg::fwdFromMem: return aluResultM;
            rvPkg::fwdFromWb:  return resultW;
            default:           return regVal;
        endcase
    endfunction

    always_comb begin
        selA       = pickSource(rs1E);
        selB       = pickSource(rs2E);
        srcAE      = muxOperand(selA, rd1E);
        writeDataE = muxOperand(selB, rd2E);
    end

endmodule

/* logic/idExReg.sv */
module idExReg #(
    parameter int dataWidth    = 32,
    parameter int regAddrWidth = 5
) (
    input  logic              clk,
    input  logic              rstN,
    input  logic              clr,

    input  logic              regWriteD,
    input  rvPkg::resultKind  resultSrcD,
    input  logic              memWriteD,
    input  logic              byteAddrD,
    input  rvPkg::jumpKind    jumpTypeD,
    input  rvPkg::branchKind  branchTypeD,
    input  rvPkg::aluOp       aluControlD,
    input  logic              aluSrcD,
    input  rvPkg::dataWord    rd1D,
    input  rvPkg::dataWord    rd2D,
    input  rvPkg::dataWord    pcD,
    input  rvPkg::regAddr     rs1D,
    input  rvPkg::regAddr     rs2D,
    input  rvPkg::regAddr     rdD,
    input  rvPkg::dataWord    immExtD,
    input  rvPkg::dataWord    pcPlus4D,

    output logic              regWriteE,
    output rvPkg::resultKind  resultSrcE,
    output logic              memWriteE,
    output logic              byteAddrE,
    output rvPkg::jumpKind    jumpTypeE,
    output rvPkg::branchKind  branchTypeE,
    output rvPkg::aluOp       aluControlE,
    output logic              aluSrcE,
    output rvPkg::dataWord    rd1E,
    output rvPkg::dataWord    rd2E,
    output rvPkg::dataWord    pcE,
    output rvPkg::regAddr     rs1E,
    output rvPkg::regAddr     rs2E,
    output rvPkg::regAddr     rdE,
    output rvPkg::dataWord    immExtE,
    output rvPkg::dataWord    pcPlus4E
);

    localparam logic [dataWidth-1:0]    zeroWord = {dataWidth{1'b0}};
    localparam logic [regAddrWidth-1:0] zeroAddr = {regAddrWidth{1'b0}};

    // a flush loads an all-zero bubble: no write, no store, no redirect
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            regWriteE   <= 1'b0;
            resultSrcE  <= rvPkg::resAlu;
            memWriteE   <= 1'b0;
            byteAddrE   <= 1'b0;
            jumpTypeE   <= rvPkg::jmpNone;
            branchTypeE <= rvPkg::brNone;
            aluControlE <= rvPkg::aluAdd;
            aluSrcE     <= 1'b0;
            rd1E        <= zeroWord;
            rd2E        <= zeroWord;
            pcE         <= zeroWord;
            rs1E        <= zeroAddr;
            rs2E        <= zeroAddr;
            rdE         <= zeroAddr;
            immExtE     <= zeroWord;
            pcPlus4E    <= zeroWord;
        end else begin
            regWriteE   <= clr ? 1'b0 : regWriteD;
            resultSrcE  <= clr ? rvPkg::resAlu : resultSrcD;
            memWriteE   <= clr ? 1'b0 : memWriteD;
            byteAddrE   <= clr ? 1'b0 : byteAddrD;
            jumpTypeE   <= clr ? rvPkg::jmpNone : jumpTypeD;
            branchTypeE <= clr ? rvPkg::brNone : branchTypeD;
            aluControlE <= clr ? rvPkg::aluAdd : aluControlD;
            aluSrcE     <= clr ? 1'b0 : aluSrcD;
            rd1E        <= clr ? zeroWord : rd1D;
            rd2E        <= clr ? zeroWord : rd2D;
            pcE         <= clr ? zeroWord : pcD;
            rs1E        <= clr ? zeroAddr : rs1D;
            rs2E        <= clr ? zeroAddr : rs2D;
            rdE         <= clr ? zeroAddr : rdD;
            immExtE     <= clr ? zeroWord : immExtD;
            pcPlus4E    <= clr ? zeroWord : pcPlus4D;
        end
    end

endmodule

/* logic/rvPkg.sv */
package rvPkg;

    // operands, pcs, immediates and results
    typedef logic [31:0] dataWord;

    // register file index
    typedef logic [4:0] regAddr;

    // shift amount comes from the low 5 bits of operand b
    typedef enum logic [2:0] {
        aluAdd = 3'd0,
        aluSub = 3'd1,
        aluAnd = 3'd2,
        aluOr  = 3'd3,
        aluXor = 3'd4,
        aluSlt = 3'd5,
        aluSll = 3'd6,
        aluSrl = 3'd7
    } aluOp;

    // blt compares signed
    typedef enum logic [1:0] {
        brNone = 2'd0,
        brBeq  = 2'd1,
        brBne  = 2'd2,
        brBlt  = 2'd3
    } branchKind;

    typedef enum logic [1:0] {
        jmpNone = 2'd0,
        jmpJal  = 2'd1,
        jmpJalr = 2'd2
    } jumpKind;

    // selects what writeback takes as the register result
    typedef enum logic [1:0] {
        resAlu     = 2'd0,
        resMem     = 2'd1,
        resPcPlus4 = 2'd2
    } resultKind;

    // operand source picked by forwarding
    typedef enum logic [1:0] {
        fwdRegFile = 2'd0,
        fwdFromMem = 2'd1,
        fwdFromWb  = 2'd2
    } fwdSel;

endpackage

/* run.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary -j 0 --top-module executeStageTb -f executeStage.f \
    && ./obj_dir/VexecuteStageTb > sim.log 2>&1 \
    || echo ">>> FAIL" >> sim.log
cat sim.log
grep -q ">>> FAIL" sim.log && exit 1 || exit 0
